// ==== source/ctrlPkg.sv ====
package ctrlPkg;

	// Major RV64I opcodes
	localparam logic [6:0] opR = 7'b0110011;
	localparam logic [6:0] opI = 7'b0010011;
	localparam logic [6:0] opLoadCode = 7'b0000011;
	localparam logic [6:0] opStoreCode = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJalrCode = 7'b1100111;
	localparam logic [6:0] opLuiCode = 7'b0110111;
	localparam logic [6:0] opJalCode = 7'b1101111;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rFmt_t;

	typedef struct packed {
		logic [11:0] imm12; // Upper six bits select srli/srai
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} iFmt_t;

	typedef union packed {
		rFmt_t rFmt;
		iFmt_t iFmt;
	} instrWord_t;

	typedef enum logic [4:0] {
		opAdd, opSub, opAnd, opSlt,
		opAddi, opSlti, opSlli, opSrli, opSrai, opNop,
		opLoad, opStore,
		opBeq, opBne, opBge, opBlt,
		opLui, opJal, opJalr,
		opIllegal
	} opClass_t;

	// Access size shared by loads and stores
	typedef logic [2:0] memSize_t;
	localparam memSize_t sizeNone = 3'd0;
	localparam memSize_t sizeDouble = 3'd1;
	localparam memSize_t sizeWord = 3'd2;
	localparam memSize_t sizeHalf = 3'd3;
	localparam memSize_t sizeByte = 3'd4;
	localparam memSize_t sizeWordU = 3'd5; // Unsigned loads only
	localparam memSize_t sizeHalfU = 3'd6;
	localparam memSize_t sizeByteU = 3'd7;

	typedef enum logic [4:0] {
		sReset, sFetch, sDecode,
		sAluAdd, sAluSub, sAluAnd, sAluImm, sSlt, sSltImm, sWriteBack,
		sShiftLeft, sShiftRight, sShiftArith,
		sLoadAddr, sLoadMem1, sLoadMem2, sLoadWrite,
		sStoreAddr, sStoreWrite,
		sBeq, sBne, sBge, sBlt,
		sLuiPrep, sLuiWrite,
		sJalLink, sJalrLink, sJump
	} ctrlState_t;

	typedef enum logic [2:0] {
		aluLoad = 3'd0,
		aluAdd = 3'd1,
		aluSub = 3'd2,
		aluAnd = 3'd3,
		aluCmp = 3'd7
	} aluOp_t;

	typedef enum logic [1:0] {
		shLeft = 2'd0,
		shRightLogic = 2'd1,
		shRightArith = 2'd2
	} shift_t;

	typedef struct packed {
		logic pcWrite;
		logic pcWriteCond;
		logic irWrite;
		logic memRead;
		logic memWrite;
		logic regWrite;
		logic loadRegA;
		logic loadRegB;
		logic loadRegAluOut;
		logic loadRegMemData;
		aluOp_t aluOp;
		logic [2:0] selMuxA;
		logic [2:0] selMuxB;
		logic [2:0] selMuxMem; // Register write data source
		logic selMuxAlu;
		logic selMuxPC;
		shift_t shift;
	} ctrlWord_t;

endpackage

// ==== source/instrDecode.sv ====
module instrDecode (
	input ctrlPkg::instrWord_t instr,
	output ctrlPkg::opClass_t opClass,
	output ctrlPkg::memSize_t memSize
);
	import ctrlPkg::*;

	always_comb begin
		opClass = opIllegal;
		memSize = sizeNone;
		case (instr.rFmt.opcode)
			opR: begin
				if (instr.rFmt.funct7 == 7'b0000000) begin
					case (instr.rFmt.funct3)
						3'b000: opClass = opAdd;
						3'b111: opClass = opAnd;
						3'b010: opClass = opSlt;
						default: opClass = opIllegal;
					endcase
				end else if (instr.rFmt.funct7 == 7'b0100000 && instr.rFmt.funct3 == 3'b000) begin
					opClass = opSub;
				end
			end
			opI: begin
				case (instr.iFmt.funct3)
					3'b000: opClass = (instr.iFmt.imm12 == 12'd0) ? opNop : opAddi;
					3'b010: opClass = opSlti;
					3'b001: begin
						if (instr.iFmt.imm12[11:6] == 6'b000000)
							opClass = opSlli;
					end
					3'b101: begin
						if (instr.iFmt.imm12[11:6] == 6'b000000)
							opClass = opSrli;
						else if (instr.iFmt.imm12[11:6] == 6'b010000)
							opClass = opSrai;
					end
					default: opClass = opIllegal;
				endcase
			end
			opLoadCode: begin
				case (instr.rFmt.funct3)
					3'b000: memSize = sizeByte;
					3'b001: memSize = sizeHalf;
					3'b010: memSize = sizeWord;
					3'b011: memSize = sizeDouble;
					3'b100: memSize = sizeByteU;
					3'b101: memSize = sizeHalfU;
					3'b110: memSize = sizeWordU;
					default: memSize = sizeNone; // 111 is reserved
				endcase
				if (memSize != sizeNone)
					opClass = opLoad;
			end
			opStoreCode: begin
				case (instr.rFmt.funct3)
					3'b000: memSize = sizeByte;
					3'b001: memSize = sizeHalf;
					3'b010: memSize = sizeWord;
					3'b011: memSize = sizeDouble;
					default: memSize = sizeNone;
				endcase
				if (memSize != sizeNone)
					opClass = opStore;
			end
			opBranch: begin
				case (instr.rFmt.funct3)
					3'b000: opClass = opBeq;
					3'b001: opClass = opBne;
					3'b100: opClass = opBlt;
					3'b101: opClass = opBge;
					default: opClass = opIllegal; // No unsigned compares
				endcase
			end
			opJalrCode: begin
				if (instr.rFmt.funct3 == 3'b000)
					opClass = opJalr;
			end
			opLuiCode: opClass = opLui;
			opJalCode: opClass = opJal;
			default: opClass = opIllegal;
		endcase
	end

endmodule

// ==== source/ctrlSequencer.sv ====
module ctrlSequencer (
	input logic rst,
	input logic clk,
	input ctrlPkg::opClass_t opClass,
	output ctrlPkg::ctrlState_t state
);
	import ctrlPkg::*;

	ctrlState_t nextState;

	always_ff @(posedge rst or posedge clk) begin
		if (clk)
			state <= sReset;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = sReset;
		case (state)
			sReset: nextState = sFetch;
			sFetch: nextState = sDecode;
			sDecode: begin
				case (opClass)
					opAdd: nextState = sAluAdd;
					opSub: nextState = sAluSub;
					opAnd: nextState = sAluAnd;
					opSlt: nextState = sSlt;
					opAddi: nextState = sAluImm;
					opSlti: nextState = sSltImm;
					opSlli: nextState = sShiftLeft;
					opSrli: nextState = sShiftRight;
					opSrai: nextState = sShiftArith;
					opLoad: nextState = sLoadAddr;
					opStore: nextState = sStoreAddr;
					opBeq: nextState = sBeq;
					opBne: nextState = sBne;
					opBge: nextState = sBge;
					opBlt: nextState = sBlt;
					opLui: nextState = sLuiPrep;
					opJal: nextState = sJalLink;
					opJalr: nextState = sJalrLink;
					opNop, opIllegal: nextState = sFetch; // Skip sReset
					default: nextState = sFetch;
				endcase
			end

			// Arithmetic results pass through ALUOut first
			sAluAdd, sAluSub, sAluAnd, sAluImm, sSlt, sSltImm: begin
				nextState = sWriteBack;
			end
			sWriteBack: nextState = sReset;

			// Shifter writes the register file directly
			sShiftLeft, sShiftRight, sShiftArith: nextState = sReset;

			sLoadAddr: nextState = sLoadMem1;
			sLoadMem1: nextState = sLoadMem2;
			sLoadMem2: nextState = sLoadWrite;
			sLoadWrite: nextState = sReset;

			sStoreAddr: nextState = sStoreWrite;
			sStoreWrite: nextState = sReset;

			// Taken or not, the encoder handles the PC update
			sBeq, sBne, sBge, sBlt: nextState = sReset;

			sLuiPrep: nextState = sLuiWrite;
			sLuiWrite: nextState = sReset;

			sJalLink, sJalrLink: nextState = sJump;
			sJump: nextState = sReset;

			default: nextState = sReset;
		endcase
	end

endmodule

// ==== source/ctrlEncoder.sv ====
module ctrlEncoder (
	input logic rst,
	input logic clk,
	input ctrlPkg::ctrlState_t state,
	input ctrlPkg::memSize_t memSize,
	input logic aluZero,
	input logic aluLess,
	output ctrlPkg::ctrlWord_t ctrl,
	output ctrlPkg::memSize_t loadType,
	output ctrlPkg::memSize_t storeType
);
	import ctrlPkg::*;

	logic branchTaken;

	always_comb begin
		ctrl = '0;
		branchTaken = 1'b0;
		case (state)
			sFetch: begin
				ctrl.irWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.pcWrite = 1'b1; // PC + 4
				ctrl.selMuxB = 3'd1;
				ctrl.selMuxMem = 3'd1;
				ctrl.aluOp = aluAdd;
			end
			sDecode: begin
				ctrl.memRead = 1'b1;
				ctrl.loadRegA = 1'b1;
				ctrl.loadRegB = 1'b1;
				ctrl.loadRegAluOut = 1'b1; // Branch target ahead of time
				ctrl.selMuxB = 3'd3;
				ctrl.aluOp = aluAdd;
			end
			sAluAdd, sAluSub, sAluAnd: begin
				ctrl.selMuxA = 3'd1;
				ctrl.loadRegAluOut = 1'b1;
				if (state == sAluSub)
					ctrl.aluOp = aluSub;
				else if (state == sAluAnd)
					ctrl.aluOp = aluAnd;
				else
					ctrl.aluOp = aluAdd;
			end
			sAluImm: begin
				ctrl.selMuxA = 3'd1;
				ctrl.selMuxB = 3'd2;
				ctrl.loadRegAluOut = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			sSlt, sSltImm: begin
				ctrl.selMuxA = 3'd1;
				ctrl.selMuxB = (state == sSltImm) ? 3'd2 : 3'd0;
				ctrl.selMuxAlu = 1'b1; // Less flag as result
				ctrl.loadRegAluOut = 1'b1;
				ctrl.aluOp = aluCmp;
			end
			sWriteBack: ctrl.regWrite = 1'b1;
			sShiftLeft, sShiftRight, sShiftArith: begin
				ctrl.regWrite = 1'b1;
				ctrl.selMuxMem = 3'd3;
				if (state == sShiftRight)
					ctrl.shift = shRightLogic;
				else if (state == sShiftArith)
					ctrl.shift = shRightArith;
				else
					ctrl.shift = shLeft;
			end
			sLoadAddr, sStoreAddr: begin
				ctrl.selMuxA = 3'd1;
				ctrl.selMuxB = 3'd2;
				ctrl.selMuxMem = 3'd1;
				ctrl.loadRegAluOut = 1'b1;
				ctrl.aluOp = aluAdd;
			end
			sLoadMem1, sLoadMem2: begin
				ctrl.memRead = 1'b1;
				ctrl.loadRegMemData = 1'b1;
			end
			sLoadWrite: begin
				ctrl.regWrite = 1'b1;
				ctrl.selMuxMem = 3'd1;
			end
			sStoreWrite: ctrl.memWrite = 1'b1;
			sBeq, sBne, sBge, sBlt: begin
				ctrl.selMuxA = 3'd1;
				ctrl.selMuxMem = 3'd1;
				ctrl.aluOp = (state == sBeq || state == sBne) ? aluSub : aluCmp;
				case (state)
					sBeq: branchTaken = aluZero;
					sBne: branchTaken = !aluZero;
					sBge: branchTaken = !aluLess;
					default: branchTaken = aluLess;
				endcase
				ctrl.pcWrite = branchTaken;
				ctrl.pcWriteCond = branchTaken;
				ctrl.selMuxPC = branchTaken;
			end
			sLuiPrep: ctrl.selMuxB = 3'd2; // Immediate onto the B path
			sLuiWrite: begin
				ctrl.regWrite = 1'b1;
				ctrl.selMuxB = 3'd2;
				ctrl.selMuxMem = 3'd2;
			end
			sJalLink, sJalrLink: begin
				// Save return address, compute target into ALUOut
				ctrl.regWrite = 1'b1;
				ctrl.loadRegAluOut = 1'b1;
				ctrl.selMuxMem = 3'd7;
				ctrl.selMuxPC = 1'b1;
				ctrl.selMuxA = (state == sJalrLink) ? 3'd1 : 3'd0;
				ctrl.selMuxB = (state == sJalrLink) ? 3'd2 : 3'd3;
				ctrl.aluOp = aluAdd;
			end
			sJump: begin
				ctrl.pcWrite = 1'b1;
				ctrl.selMuxPC = 1'b1;
				ctrl.selMuxA = 3'd1;
				ctrl.selMuxB = 3'd3;
				ctrl.aluOp = aluAdd;
			end
			default: ctrl = '0; // sReset
		endcase
	end

	// Size latched as the address state is left
	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			loadType <= sizeNone;
			storeType <= sizeNone;
		end else begin
			if (state == sLoadAddr)
				loadType <= memSize;
			if (state == sStoreAddr)
				storeType <= memSize;
		end
	end

endmodule

// ==== source/controlUnit.sv ====
module controlUnit (
	input logic rst,
	input logic clk,
	input ctrlPkg::instrWord_t instr,
	input logic aluZero,
	input logic aluLess,
	output ctrlPkg::ctrlWord_t ctrl,
	output ctrlPkg::memSize_t loadType,
	output ctrlPkg::memSize_t storeType
);
	import ctrlPkg::*;

	opClass_t opClass;
	memSize_t memSize;
	ctrlState_t state;

	instrDecode decoder (
		.instr(instr),
		.opClass(opClass),
		.memSize(memSize)
	);

	ctrlSequencer sequencer (
		.rst(rst),
		.clk(clk),
		.opClass(opClass),
		.state(state)
	);

	// Strobes follow the state, sizes are registered
	ctrlEncoder encoder (
		.rst(rst),
		.clk(clk),
		.state(state),
		.memSize(memSize),
		.aluZero(aluZero),
		.aluLess(aluLess),
		.ctrl(ctrl),
		.loadType(loadType),
		.storeType(storeType)
	);

endmodule

// ==== tests/controlUnit_assert.sv ====
module controlUnitAssert (
	input logic rst,
	input logic clk,
	input ctrlPkg::ctrlWord_t ctrl,
	input ctrlPkg::memSize_t storeType
);

	int failCount = 0;

	noFetchWrite: assert property (@(posedge rst) disable iff (clk)
		!(ctrl.irWrite && ctrl.regWrite))
	else begin
		failCount++;
		$error("irWrite and regWrite high in the same cycle");
	end

	// A store always has a latched size
	storeSized: assert property (@(posedge rst) disable iff (clk)
		ctrl.memWrite |-> (storeType != 3'd0))
	else begin
		failCount++;
		$error("memWrite with storeType 0");
	end

	singleFetch: assert property (@(posedge rst) disable iff (clk)
		!(ctrl.irWrite && $past(ctrl.irWrite)))
	else begin
		failCount++;
		$error("irWrite high two cycles in a row");
	end

	condImpliesWrite: assert property (@(posedge rst) disable iff (clk)
		ctrl.pcWriteCond |-> ctrl.pcWrite)
	else begin
		failCount++;
		$error("pcWriteCond without pcWrite");
	end

endmodule

bind controlUnit controlUnitAssert assertions (
	.rst(rst),
	.clk(clk),
	.ctrl(ctrl),
	.storeType(storeType)
);

// ==== tests/controlTable.svh ====
`ifndef CONTROL_TABLE_SVH
`define CONTROL_TABLE_SVH

task automatic buildTable();
	// Columns are word, aluZero, aluLess, random regs, period, regWrite, memWrite,
	// pcWriteCond, loadType, storeType
	addRow(encR(7'b0000000, 3'b000, codeR), 0, 0, 0, 5, 1, 0, 0, 0, 0); // add
	addRow(encR(7'b0100000, 3'b000, codeR), 0, 0, 1, 5, 1, 0, 0, 0, 0); // sub
	addRow(encR(7'b0000000, 3'b111, codeR), 0, 0, 0, 5, 1, 0, 0, 0, 0); // and
	addRow(encR(7'b0000000, 3'b010, codeR), 0, 0, 1, 5, 1, 0, 0, 0, 0); // slt
	addRow(encI(12'h010, 3'b000, codeImm), 0, 0, 0, 5, 1, 0, 0, 0, 0); // addi
	addRow(32'h0000_0013, 0, 0, 0, 2, 0, 0, 0, 0, 0); // nop
	addRow(encI(12'hffb, 3'b010, codeImm), 0, 0, 1, 5, 1, 0, 0, 0, 0); // slti
	addRow(encI(12'h003, 3'b001, codeImm), 0, 0, 0, 4, 1, 0, 0, 0, 0); // slli
	addRow(encI(12'h005, 3'b101, codeImm), 0, 0, 1, 4, 1, 0, 0, 0, 0); // srli
	addRow(encI(12'h405, 3'b101, codeImm), 0, 0, 0, 4, 1, 0, 0, 0, 0); // srai

	// Sizes stick until the next access of the same kind
	addRow(encI(12'h008, 3'b000, codeLoad), 0, 0, 0, 7, 1, 0, 0, 4, 0); // lb
	addRow(encR(7'b0000000, 3'b000, codeStore), 0, 0, 0, 5, 0, 1, 0, 4, 4); // sb
	addRow(encI(12'h008, 3'b001, codeLoad), 0, 0, 0, 7, 1, 0, 0, 3, 4); // lh
	addRow(encI(12'h010, 3'b010, codeLoad), 0, 0, 1, 7, 1, 0, 0, 2, 4); // lw
	addRow(encR(7'b0000001, 3'b001, codeStore), 0, 0, 0, 5, 0, 1, 0, 2, 3); // sh
	addRow(encI(12'h018, 3'b011, codeLoad), 0, 0, 0, 7, 1, 0, 0, 1, 3); // ld
	addRow(encR(7'b0000000, 3'b010, codeStore), 0, 0, 1, 5, 0, 1, 0, 1, 2); // sw
	addRow(encI(12'h001, 3'b100, codeLoad), 0, 0, 0, 7, 1, 0, 0, 7, 2); // lbu
	addRow(encR(7'b0000010, 3'b011, codeStore), 0, 0, 0, 5, 0, 1, 0, 7, 1); // sd
	addRow(encI(12'h002, 3'b101, codeLoad), 0, 0, 1, 7, 1, 0, 0, 6, 1); // lhu
	addRow(encI(12'h004, 3'b110, codeLoad), 0, 0, 0, 7, 1, 0, 0, 5, 1); // lwu

	// Both outcomes of each branch with the other flag held fixed
	addRow(encR(7'b0000000, 3'b000, codeBranch), 1, 1, 0, 4, 0, 0, 1, 5, 1); // beq
	addRow(encR(7'b0000000, 3'b000, codeBranch), 0, 1, 1, 4, 0, 0, 0, 5, 1);
	addRow(encR(7'b0000000, 3'b001, codeBranch), 0, 0, 0, 4, 0, 0, 1, 5, 1); // bne
	addRow(encR(7'b0000000, 3'b001, codeBranch), 1, 0, 0, 4, 0, 0, 0, 5, 1);
	addRow(encR(7'b0000000, 3'b101, codeBranch), 1, 0, 0, 4, 0, 0, 1, 5, 1); // bge
	addRow(encR(7'b0000000, 3'b101, codeBranch), 1, 1, 1, 4, 0, 0, 0, 5, 1);
	addRow(encR(7'b0000000, 3'b100, codeBranch), 0, 1, 0, 4, 0, 0, 1, 5, 1); // blt
	addRow(encR(7'b0000000, 3'b100, codeBranch), 0, 0, 0, 4, 0, 0, 0, 5, 1);

	addRow(encI(12'h123, 3'b101, codeLui), 0, 0, 0, 5, 1, 0, 0, 5, 1); // lui
	addRow(encI(12'h040, 3'b000, codeJal), 0, 0, 1, 5, 1, 0, 0, 5, 1); // jal
	addRow(encI(12'h010, 3'b000, codeJalr), 0, 0, 0, 5, 1, 0, 0, 5, 1); // jalr

	// Unsupported encodings fall back to fetch
	addRow(encI(12'h000, 3'b000, 7'b1111111), 0, 0, 0, 2, 0, 0, 0, 5, 1);
	addRow(encR(7'b0000001, 3'b000, codeR), 0, 0, 0, 2, 0, 0, 0, 5, 1); // mul
	addRow(encI(12'h000, 3'b111, codeLoad), 0, 0, 0, 2, 0, 0, 0, 5, 1);
	addRow(encR(7'b0000000, 3'b110, codeBranch), 1, 1, 0, 2, 0, 0, 0, 5, 1); // bltu
	addRow(encR(7'b0000000, 3'b000, codeR), 0, 0, 1, 5, 1, 0, 0, 5, 1);
endtask

`endif

// ==== tests/controlTb.sv ====
module controlTb;
	import ctrlPkg::*;

	localparam int clockPeriod = 4;

	// RV64I major opcodes
	localparam logic [6:0] codeR = 7'b0110011;
	localparam logic [6:0] codeImm = 7'b0010011;
	localparam logic [6:0] codeLoad = 7'b0000011;
	localparam logic [6:0] codeStore = 7'b0100011;
	localparam logic [6:0] codeBranch = 7'b1100011;
	localparam logic [6:0] codeJalr = 7'b1100111;
	localparam logic [6:0] codeLui = 7'b0110111;
	localparam logic [6:0] codeJal = 7'b1101111;

	typedef struct packed {
		logic [31:0] instr;
		logic aluZero;
		logic aluLess;
		logic randRegs; // rd and rs1 drawn at random
		int period;
		int regWrites;
		int memWrites;
		int condWrites;
		int loadSize;
		int storeSize;
	} testRow_t;

	logic rst;
	logic clk;
	instrWord_t instr;
	logic aluZero;
	logic aluLess;
	ctrlWord_t ctrl;
	memSize_t loadType;
	memSize_t storeType;

	testRow_t rows[$];
	integer seed;
	int watchdogCycles = 0;

	controlUnit dut (
		.rst(rst),
		.clk(clk),
		.instr(instr),
		.aluZero(aluZero),
		.aluLess(aluLess),
		.ctrl(ctrl),
		.loadType(loadType),
		.storeType(storeType)
	);

	always #(clockPeriod / 2) rst = ~rst;

	// Fixed registers rd 5, rs1 6, rs2 7
	function automatic logic [31:0] encR(input logic [6:0] funct7, input logic [2:0] funct3,
			input logic [6:0] opcode);
		return {funct7, 5'd7, 5'd6, funct3, 5'd5, opcode};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [2:0] funct3,
			input logic [6:0] opcode);
		return {imm, 5'd6, funct3, 5'd5, opcode};
	endfunction

	function automatic logic [9:0] strobesOf(input ctrlWord_t word);
		return {word.pcWrite, word.pcWriteCond, word.irWrite, word.memRead, word.memWrite,
			word.regWrite, word.loadRegA, word.loadRegB, word.loadRegAluOut,
			word.loadRegMemData};
	endfunction

	task automatic addRow(input logic [31:0] word, input int zero, input int less,
			input int randRegs, input int period, input int regWrites, input int memWrites,
			input int condWrites, input int loadSize, input int storeSize);
		testRow_t row;
		row.instr = word;
		row.aluZero = (zero != 0);
		row.aluLess = (less != 0);
		row.randRegs = (randRegs != 0);
		row.period = period;
		row.regWrites = regWrites;
		row.memWrites = memWrites;
		row.condWrites = condWrites;
		row.loadSize = loadSize;
		row.storeSize = storeSize;
		rows.push_back(row);
	endtask

	`include "controlTable.svh"

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAIL time=%0t signal=%s actual=%0d expected=%0d",
				$time, name, actual, expected);
			$display("TB FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	initial begin
		testRow_t row;
		logic [31:0] word;
		int total;
		int cycles;
		int regCount;
		int memCount;
		int condCount;

		rst = 1'b0;
		clk = 1'b1;
		instr = 32'h0000_0013;
		aluZero = 1'b0;
		aluLess = 1'b0;
		seed = 96;
		buildTable();
		total = 50;
		foreach (rows[i])
			total += rows[i].period;
		watchdogCycles = total;

		repeat (7) begin
			@(negedge rst);
			checkValue("strobes in reset", 32'(strobesOf(ctrl)), 32'd0);
		end
		@(posedge rst); // Eighth edge in reset
		#1 clk = 1'b0;
		@(negedge rst);
		checkValue("strobes after reset", 32'(strobesOf(ctrl)), 32'd0);
		@(negedge rst);
		checkValue("irWrite", 32'(ctrl.irWrite), 32'd1);

		// Each row starts in a fetch cycle and runs up to the next one
		foreach (rows[i]) begin
			row = rows[i];
			word = row.instr;
			if (row.randRegs) begin
				word[19:15] = 5'($random(seed));
				word[11:7] = 5'($random(seed));
			end
			@(posedge rst);
			#1;
			instr = word; // IR loaded at the end of fetch
			aluZero = row.aluZero;
			aluLess = row.aluLess;
			cycles = 0;
			regCount = 0;
			memCount = 0;
			condCount = 0;
			do begin
				@(negedge rst);
				cycles++;
				if (!ctrl.irWrite) begin
					if (ctrl.regWrite)
						regCount++;
					if (ctrl.memWrite)
						memCount++;
					if (ctrl.pcWriteCond)
						condCount++;
				end
			end while (!ctrl.irWrite);
			checkValue($sformatf("row %0d period", i), cycles, row.period);
			checkValue($sformatf("row %0d regWrite", i), regCount, row.regWrites);
			checkValue($sformatf("row %0d memWrite", i), memCount, row.memWrites);
			checkValue($sformatf("row %0d pcWriteCond", i), condCount, row.condWrites);
			checkValue($sformatf("row %0d loadType", i), 32'(loadType), row.loadSize);
			checkValue($sformatf("row %0d storeType", i), 32'(storeType), row.storeSize);
		end

		if (dut.assertions.failCount == 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			$display("Bound assertions on the control outputs failed %0d times",
				dut.assertions.failCount);
			$display("TB FAILED");
			$fatal(1, "Assertion failures");
		end
	end

	initial begin
		wait (watchdogCycles > 0);
		#(watchdogCycles * clockPeriod);
		$display("Watchdog expired before all table rows were applied");
		$display("TB FAILED");
		$fatal(1, "Timeout");
	end

	// Tally kept by the bound assertion module
	always @(negedge rst) begin
		if (dut.assertions.failCount != 0) begin
			$display("A bound assertion on the control outputs failed before time %0t", $time);
			$display("TB FAILED");
			$fatal(1, "Assertion failure");
		end
	end

endmodule

// ==== vlog.f ====
+incdir+tests
source/ctrlPkg.sv
source/instrDecode.sv
source/ctrlSequencer.sv
source/ctrlEncoder.sv
source/controlUnit.sv
tests/controlUnit_assert.sv
tests/controlTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the control unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module controlTb -o controlSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/controlSim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
echo "Simulation finished"
exit 0
